// ==== Bender.yml ====
package:
  name: imm_engine

sources:
  - imm_pkg.sv
  - imm_step_if.sv
  - imm_ctrl.sv
  - imm_mixer.sv
  - imm_prob_update.sv
  - imm_top.sv
  - target: simulation
    files:
      - imm_chk.sv
      - tb_imm_top.sv

// ==== imm_chk.sv ====
`timescale 1ns/1ps

module imm_chk (
    input logic clk,
    input logic rst_n,
    input logic meas_valid,
    input logic ready,
    input logic mix_valid,
    input logic out_valid,
    input logic done
);

    // Failures so far, read back at the end of the run
    int fail_count = 0;

    // ----------------------------------------
    // Strobes last one cycle
    // ----------------------------------------
    a_mix_single: assert property (@(posedge clk) disable iff (!rst_n)
        mix_valid |=> !mix_valid)
        else begin
            fail_count++;
            $error("mix_valid high two cycles running");
        end

    a_out_single: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |=> !out_valid)
        else begin
            fail_count++;
            $error("out_valid high two cycles running");
        end

    a_done_single: assert property (@(posedge clk) disable iff (!rst_n)
        done |=> !done)
        else begin
            fail_count++;
            $error("done high two cycles running");
        end

    // Completion order
    a_done_after_out: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |=> done)
        else begin
            fail_count++;
            $error("done did not follow out_valid");
        end

    // ----------------------------------------
    // Busy from acceptance through done
    // ----------------------------------------
    a_busy_start: assert property (@(posedge clk) disable iff (!rst_n)
        (ready && meas_valid) |=> !ready)
        else begin
            fail_count++;
            $error("ready stayed high after acceptance");
        end

    // Ready may only come back after done
    a_busy_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (!ready && !done) |=> !ready)
        else begin
            fail_count++;
            $error("ready rose before done");
        end

endmodule

bind imm_top imm_chk u_chk (
    .clk        (clk),
    .rst_n      (rst_n),
    .meas_valid (meas_valid),
    .ready      (ready),
    .mix_valid  (mix_valid),
    .out_valid  (out_valid),
    .done       (done)
);

// ==== imm_ctrl.sv ====
`timescale 1ns/1ps

module imm_ctrl (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       meas_valid,
    input  logic       init,
    input  logic       filt_valid,
    output logic       ready,
    output logic       mix_valid,
    output logic       out_valid,
    output logic       done,
    imm_step_if.ctrl   step_bus
);

    // One state per cycle of the IMM sequence, wait loops on the filters
    typedef enum logic [3:0] {
        S_IDLE,
        S_INIT,
        S_CBAR,
        S_MU_IJ,
        S_MIX,
        S_RUN,
        S_WAIT,
        S_UPDATE,
        S_COMBINE,
        S_OUT,
        S_DONE
    } state_e;

    state_e state;
    state_e next_state;

    // ----------------------------------------
    // Next state and step code
    // ----------------------------------------
    always_comb begin
        next_state = state;
        case (state)
            // Requests only seen in idle
            S_IDLE:    if (meas_valid) next_state = init ? S_INIT : S_CBAR;
            S_INIT:    next_state = S_DONE;
            S_CBAR:    next_state = S_MU_IJ;
            S_MU_IJ:   next_state = S_MIX;
            S_MIX:     next_state = S_RUN;
            // Filters may answer as early as the mix_valid cycle
            S_RUN,
            S_WAIT:    next_state = filt_valid ? S_UPDATE : S_WAIT;
            S_UPDATE:  next_state = S_COMBINE;
            S_COMBINE: next_state = S_OUT;
            S_OUT:     next_state = S_DONE;
            S_DONE:    next_state = S_IDLE;
            default:   next_state = S_IDLE;
        endcase
    end

    always_comb begin
        case (state)
            S_INIT:    step_bus.step = imm_pkg::STEP_INIT;
            S_CBAR:    step_bus.step = imm_pkg::STEP_CBAR;
            S_MU_IJ:   step_bus.step = imm_pkg::STEP_MU_IJ;
            S_MIX:     step_bus.step = imm_pkg::STEP_MIX;
            // Filtered states captured in the very cycle filt_valid is high
            S_RUN,
            S_WAIT:    step_bus.step = filt_valid ? imm_pkg::STEP_LOAD : imm_pkg::STEP_NONE;
            S_UPDATE:  step_bus.step = imm_pkg::STEP_UPDATE;
            S_COMBINE: step_bus.step = imm_pkg::STEP_COMBINE;
            default:   step_bus.step = imm_pkg::STEP_NONE;
        endcase
    end

    // ----------------------------------------
    // State and strobes
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= S_IDLE;
            ready     <= 1'b1;
            mix_valid <= 1'b0;
            out_valid <= 1'b0;
            done      <= 1'b0;
        end else begin
            state     <= next_state;
            // Strobes track the state they belong to
            ready     <= (next_state == S_IDLE);
            mix_valid <= (next_state == S_RUN);
            out_valid <= (next_state == S_OUT);
            done      <= (next_state == S_DONE);
        end
    end

endmodule

// ==== imm_mixer.sv ====
`timescale 1ns/1ps

module imm_mixer #(
    parameter int N_MODELS  = imm_pkg::DEF_N_MODELS,
    parameter int STATE_DIM = imm_pkg::DEF_STATE_DIM
) (
    input  logic         clk,
    input  logic         rst_n,
    input  imm_pkg::fp_t p_stay,
    input  imm_pkg::fp_t x_init       [STATE_DIM],
    input  imm_pkg::fp_t x_filt_model [N_MODELS][STATE_DIM],
    output imm_pkg::fp_t x_mixed      [N_MODELS][STATE_DIM],
    imm_step_if.mixer    step_bus
);

    imm_pkg::fp_t p_switch;
    imm_pkg::fp_t pi_mat    [N_MODELS][N_MODELS];
    imm_pkg::fp_t x_model   [N_MODELS][STATE_DIM];
    imm_pkg::fp_t c_bar_q   [N_MODELS];
    imm_pkg::fp_t c_bar_nxt [N_MODELS];
    imm_pkg::fp_t mu_ij     [N_MODELS][N_MODELS];
    imm_pkg::fp_t mu_ij_nxt [N_MODELS][N_MODELS];
    imm_pkg::fp_t mix_nxt   [N_MODELS][STATE_DIM];

    // ----------------------------------------
    // Transition matrix
    // ----------------------------------------

    // Off-diagonal mass split evenly
    assign p_switch = imm_pkg::fp_div(imm_pkg::FP_ONE - p_stay,
                                      imm_pkg::fp_t'((N_MODELS - 1) <<< 16));

    always_comb begin
        for (int i = 0; i < N_MODELS; i++) begin
            for (int j = 0; j < N_MODELS; j++) begin
                pi_mat[i][j] = (i == j) ? p_stay : p_switch;
            end
        end
    end

    // ----------------------------------------
    // Mixing arithmetic
    // ----------------------------------------

    // c_bar[j] = sum_i PI[i][j] * mu[i]
    always_comb begin
        imm_pkg::fp_t acc;
        for (int j = 0; j < N_MODELS; j++) begin
            acc = imm_pkg::FP_ZERO;
            for (int i = 0; i < N_MODELS; i++) begin
                acc = acc + imm_pkg::fp_mul(pi_mat[i][j], step_bus.mu[i]);
            end
            c_bar_nxt[j] = acc;
        end
    end

    // mu(i|j), zero weight when c_bar[j] is zero
    always_comb begin
        for (int i = 0; i < N_MODELS; i++) begin
            for (int j = 0; j < N_MODELS; j++) begin
                mu_ij_nxt[i][j] = (c_bar_q[j] != imm_pkg::FP_ZERO) ?
                    imm_pkg::fp_div(imm_pkg::fp_mul(pi_mat[i][j], step_bus.mu[i]), c_bar_q[j]) :
                    imm_pkg::FP_ZERO;
            end
        end
    end

    // Weighted sum of model states per target model
    always_comb begin
        imm_pkg::fp_t acc;
        for (int j = 0; j < N_MODELS; j++) begin
            for (int s = 0; s < STATE_DIM; s++) begin
                acc = imm_pkg::FP_ZERO;
                for (int i = 0; i < N_MODELS; i++) begin
                    acc = acc + imm_pkg::fp_mul(mu_ij[i][j], x_model[i][s]);
                end
                mix_nxt[j][s] = acc;
            end
        end
    end

    // ----------------------------------------
    // Registers
    // ----------------------------------------

    // Model states, cleared by reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int m = 0; m < N_MODELS; m++) begin
                x_model[m] <= '{default: imm_pkg::FP_ZERO};
            end
        end else if (step_bus.step == imm_pkg::STEP_INIT) begin
            // Same start point for every model
            for (int m = 0; m < N_MODELS; m++) begin
                x_model[m] <= x_init;
            end
        end else if (step_bus.step == imm_pkg::STEP_LOAD) begin
            x_model <= x_filt_model;
        end
    end

    // Working values, rewritten before use each cycle of the sequence
    always_ff @(posedge clk) begin
        case (step_bus.step)
            imm_pkg::STEP_INIT: begin
                for (int m = 0; m < N_MODELS; m++) begin
                    x_mixed[m] <= x_init;
                end
            end
            imm_pkg::STEP_CBAR:  c_bar_q <= c_bar_nxt;
            imm_pkg::STEP_MU_IJ: mu_ij   <= mu_ij_nxt;
            imm_pkg::STEP_MIX:   x_mixed <= mix_nxt;
            default: ;
        endcase
    end

    assign step_bus.c_bar = c_bar_q;

endmodule

// ==== imm_pkg.sv ====
package imm_pkg;

    // ----------------------------------------
    // Fixed-point format
    // ----------------------------------------

    // Signed Q16.16
    typedef logic signed [31:0] fp_t;

    localparam fp_t FP_ONE  = 32'sh0001_0000;
    localparam fp_t FP_ZERO = 32'sh0000_0000;

    // Default sizes, overridden from the top level
    localparam int DEF_N_MODELS  = 3;
    localparam int DEF_STATE_DIM = 4;

    // Model 0 starts at 0.8, the rest share what is left
    localparam fp_t MU0_INIT = 32'sh0000_CCCD;

    // ----------------------------------------
    // Step codes from controller to datapath
    // ----------------------------------------
    typedef enum logic [2:0] {
        STEP_NONE,
        STEP_INIT,
        STEP_CBAR,
        STEP_MU_IJ,
        STEP_MIX,
        STEP_LOAD,
        STEP_UPDATE,
        STEP_COMBINE
    } step_e;

    // ----------------------------------------
    // Arithmetic
    // ----------------------------------------

    // Full 64-bit product, back to Q16.16
    function automatic fp_t fp_mul(input fp_t a, input fp_t b);
        logic signed [63:0] a_w;
        logic signed [63:0] b_w;
        logic signed [63:0] prod;
        a_w  = a;
        b_w  = b;
        prod = a_w * b_w;
        // Arithmetic shift keeps the sign
        return fp_t'(prod >>> 16);
    endfunction

    // Dividend pre-scaled by 2^16 so the quotient lands in Q16.16
    // Caller guards against a zero divisor
    function automatic fp_t fp_div(input fp_t num, input fp_t den);
        logic signed [63:0] num_w;
        logic signed [63:0] den_w;
        num_w = num;
        den_w = den;
        num_w = num_w <<< 16;
        return fp_t'(num_w / den_w);
    endfunction

endpackage

// ==== imm_prob_update.sv ====
`timescale 1ns/1ps

module imm_prob_update #(
    parameter int N_MODELS  = imm_pkg::DEF_N_MODELS,
    parameter int STATE_DIM = imm_pkg::DEF_STATE_DIM
) (
    input  logic         clk,
    input  logic         rst_n,
    input  imm_pkg::fp_t likelihood   [N_MODELS],
    input  imm_pkg::fp_t x_filt_model [N_MODELS][STATE_DIM],
    output imm_pkg::fp_t x_filt       [STATE_DIM],
    imm_step_if.prob     step_bus
);

    // Share of each model other than model 0 at start
    localparam imm_pkg::fp_t MU_REST =
        (imm_pkg::FP_ONE - imm_pkg::MU0_INIT) / (N_MODELS - 1);

    imm_pkg::fp_t mu_q     [N_MODELS];
    imm_pkg::fp_t mu_def   [N_MODELS];
    imm_pkg::fp_t prod     [N_MODELS];
    imm_pkg::fp_t prod_sum;
    imm_pkg::fp_t mu_nxt   [N_MODELS];
    imm_pkg::fp_t comb_nxt [STATE_DIM];

    // Default probability vector
    always_comb begin
        for (int j = 0; j < N_MODELS; j++) begin
            mu_def[j] = (j == 0) ? imm_pkg::MU0_INIT : MU_REST;
        end
    end

    // ----------------------------------------
    // Mode probability update
    // ----------------------------------------

    // Unnormalised c_bar * likelihood and their total
    always_comb begin
        prod_sum = imm_pkg::FP_ZERO;
        for (int j = 0; j < N_MODELS; j++) begin
            prod[j]  = imm_pkg::fp_mul(step_bus.c_bar[j], likelihood[j]);
            prod_sum = prod_sum + prod[j];
        end
    end

    always_comb begin
        for (int j = 0; j < N_MODELS; j++) begin
            if (prod_sum != imm_pkg::FP_ZERO) begin
                mu_nxt[j] = imm_pkg::fp_div(prod[j], prod_sum);
            end else begin
                // Degenerate case, fall back on model 0
                mu_nxt[j] = (j == 0) ? imm_pkg::FP_ONE : imm_pkg::FP_ZERO;
            end
        end
    end

    // ----------------------------------------
    // Combined estimate
    // ----------------------------------------

    // Runs one cycle after the update so mu_q is already current
    always_comb begin
        imm_pkg::fp_t acc;
        for (int s = 0; s < STATE_DIM; s++) begin
            acc = imm_pkg::FP_ZERO;
            for (int j = 0; j < N_MODELS; j++) begin
                acc = acc + imm_pkg::fp_mul(mu_q[j], x_filt_model[j][s]);
            end
            comb_nxt[s] = acc;
        end
    end

    // ----------------------------------------
    // Registers
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mu_q   <= mu_def;
            x_filt <= '{default: imm_pkg::FP_ZERO};
        end else begin
            case (step_bus.step)
                imm_pkg::STEP_INIT:    mu_q   <= mu_def;
                imm_pkg::STEP_UPDATE:  mu_q   <= mu_nxt;
                imm_pkg::STEP_COMBINE: x_filt <= comb_nxt;
                default: ;
            endcase
        end
    end

    assign step_bus.mu = mu_q;

endmodule

// ==== imm_step_if.sv ====
`timescale 1ns/1ps

interface imm_step_if #(
    parameter int N_MODELS = imm_pkg::DEF_N_MODELS
);

    // Step ordered by the controller, one per cycle
    imm_pkg::step_e step;

    // Mode probabilities, owned by the probability unit
    imm_pkg::fp_t   mu    [N_MODELS];

    // Normalisation terms, owned by the mixer
    imm_pkg::fp_t   c_bar [N_MODELS];

    // Sequencer side
    modport ctrl (
        output step
    );

    // Mixing side needs mu for c_bar and weights
    modport mixer (
        input  step,
        input  mu,
        output c_bar
    );

    // Probability side needs c_bar for the update
    modport prob (
        input  step,
        input  c_bar,
        output mu
    );

endinterface

// ==== imm_top.sv ====
`timescale 1ns/1ps

module imm_top #(
    parameter int N_MODELS  = imm_pkg::DEF_N_MODELS,
    parameter int STATE_DIM = imm_pkg::DEF_STATE_DIM
) (
    input  logic         clk,
    input  logic         rst_n,

    // Request side
    input  logic         meas_valid,
    input  logic         init,
    output logic         ready,

    // Configuration and start state
    input  imm_pkg::fp_t p_stay,
    input  imm_pkg::fp_t x_init       [STATE_DIM],

    // Towards the external filters
    output imm_pkg::fp_t x_mixed      [N_MODELS][STATE_DIM],
    output logic         mix_valid,

    // Back from the external filters
    input  logic         filt_valid,
    input  imm_pkg::fp_t x_filt_model [N_MODELS][STATE_DIM],
    input  imm_pkg::fp_t likelihood   [N_MODELS],

    // Results
    output imm_pkg::fp_t x_filt       [STATE_DIM],
    output imm_pkg::fp_t mu           [N_MODELS],
    output logic         out_valid,
    output logic         done
);

    // Step code and shared probabilities
    imm_step_if #(.N_MODELS(N_MODELS)) step_bus ();

    // ----------------------------------------
    // Units
    // ----------------------------------------
    imm_ctrl u_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .meas_valid (meas_valid),
        .init       (init),
        .filt_valid (filt_valid),
        .ready      (ready),
        .mix_valid  (mix_valid),
        .out_valid  (out_valid),
        .done       (done),
        .step_bus   (step_bus)
    );

    imm_mixer #(
        .N_MODELS  (N_MODELS),
        .STATE_DIM (STATE_DIM)
    ) u_mixer (
        .clk          (clk),
        .rst_n        (rst_n),
        .p_stay       (p_stay),
        .x_init       (x_init),
        .x_filt_model (x_filt_model),
        .x_mixed      (x_mixed),
        .step_bus     (step_bus)
    );

    imm_prob_update #(
        .N_MODELS  (N_MODELS),
        .STATE_DIM (STATE_DIM)
    ) u_prob (
        .clk          (clk),
        .rst_n        (rst_n),
        .likelihood   (likelihood),
        .x_filt_model (x_filt_model),
        .x_filt       (x_filt),
        .step_bus     (step_bus)
    );

    // Probabilities straight off the shared bus
    assign mu = step_bus.mu;

endmodule

// ==== tb_imm_top.sv ====
`timescale 1ns/1ps

module tb_imm_top;

    localparam int N = imm_pkg::DEF_N_MODELS;
    localparam int D = imm_pkg::DEF_STATE_DIM;

    // Measurement counts per test
    localparam int N_RUN  = 10;
    localparam int N_BUSY = 6;
    // Two inits, the run, the zero-likelihood pair, the busy run
    localparam int N_MEAS = 2 + N_RUN + 2 + N_BUSY;
    localparam int WATCHDOG_CYCLES = 4 + 200 * N_MEAS;

    logic clk;
    logic rst_n;
    logic meas_req;
    logic noise;
    logic noise_en;
    logic meas_valid;
    logic init;
    logic ready;
    logic filt_valid;
    logic mix_valid;
    logic out_valid;
    logic done;

    imm_pkg::fp_t p_stay;
    imm_pkg::fp_t x_init       [D];
    imm_pkg::fp_t x_filt_model [N][D];
    imm_pkg::fp_t likelihood   [N];
    imm_pkg::fp_t x_mixed      [N][D];
    imm_pkg::fp_t x_filt       [D];
    imm_pkg::fp_t mu           [N];

    // Reference model
    imm_pkg::fp_t m_mu    [N];
    imm_pkg::fp_t m_x     [N][D];
    imm_pkg::fp_t m_cbar  [N];
    imm_pkg::fp_t m_mixed [N][D];
    imm_pkg::fp_t m_xf    [D];

    // Stray request pattern, drawn from the seeded stream
    bit noise_bits [256];
    int noise_idx;

    int errors;
    int checks;
    int tests;
    int test_err_base;
    int accepted_normal = 0;
    int mix_pulses      = 0;
    int out_pulses      = 0;

    // Stray pulses only ever overlay a busy DUT
    assign meas_valid = meas_req | (noise_en & noise);

    imm_top UUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .meas_valid   (meas_valid),
        .init         (init),
        .ready        (ready),
        .p_stay       (p_stay),
        .x_init       (x_init),
        .x_mixed      (x_mixed),
        .mix_valid    (mix_valid),
        .filt_valid   (filt_valid),
        .x_filt_model (x_filt_model),
        .likelihood   (likelihood),
        .x_filt       (x_filt),
        .mu           (mu),
        .out_valid    (out_valid),
        .done         (done)
    );

    // ----------------------------------------
    // Clock, watchdog, monitors
    // ----------------------------------------
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
        $display("Result: FAILED");
        $finish;
    end

    // Accepted requests and strobe pulses
    always @(posedge clk) begin
        if (rst_n && ready && meas_valid && !init) accepted_normal <= accepted_normal + 1;
        if (rst_n && mix_valid) mix_pulses <= mix_pulses + 1;
        if (rst_n && out_valid) out_pulses <= out_pulses + 1;
    end

    // Random request noise, decided on the falling edge
    initial begin
        noise     = 1'b0;
        noise_idx = 0;
        forever begin
            @(negedge clk);
            noise     = !ready && noise_bits[noise_idx];
            noise_idx = (noise_idx + 1) % 256;
        end
    end

    // ----------------------------------------
    // Reference arithmetic
    // ----------------------------------------

    // p_stay on the diagonal, rest split evenly
    function automatic imm_pkg::fp_t pi_entry(input int i, input int j);
        imm_pkg::fp_t p_switch;
        p_switch = imm_pkg::fp_div(imm_pkg::FP_ONE - p_stay,
                                   imm_pkg::fp_t'((N - 1) * 65536));
        return (i == j) ? p_stay : p_switch;
    endfunction

    function automatic imm_pkg::fp_t mu_default(input int j);
        return (j == 0) ? imm_pkg::MU0_INIT : (imm_pkg::FP_ONE - imm_pkg::MU0_INIT) / (N - 1);
    endfunction

    // Roughly +-100 in Q16.16
    function automatic imm_pkg::fp_t rand_state();
        return imm_pkg::fp_t'($urandom_range(32'h00C8_0000, 0)) - 32'sh0064_0000;
    endfunction

    // c_bar, weights and mixed states from the model's mu and states
    task automatic model_mix();
        imm_pkg::fp_t w [N][N];
        for (int j = 0; j < N; j++) begin
            m_cbar[j] = imm_pkg::FP_ZERO;
            for (int i = 0; i < N; i++) begin
                m_cbar[j] = m_cbar[j] + imm_pkg::fp_mul(pi_entry(i, j), m_mu[i]);
            end
        end
        for (int i = 0; i < N; i++) begin
            for (int j = 0; j < N; j++) begin
                if (m_cbar[j] == imm_pkg::FP_ZERO) w[i][j] = imm_pkg::FP_ZERO;
                else w[i][j] = imm_pkg::fp_div(imm_pkg::fp_mul(pi_entry(i, j), m_mu[i]),
                                               m_cbar[j]);
            end
        end
        for (int j = 0; j < N; j++) begin
            for (int s = 0; s < D; s++) begin
                m_mixed[j][s] = imm_pkg::FP_ZERO;
                for (int i = 0; i < N; i++) begin
                    m_mixed[j][s] = m_mixed[j][s] + imm_pkg::fp_mul(w[i][j], m_x[i][s]);
                end
            end
        end
    endtask

    // New mu from the driven likelihoods, then the combined state
    task automatic model_update();
        imm_pkg::fp_t prod [N];
        imm_pkg::fp_t total;
        total = imm_pkg::FP_ZERO;
        for (int j = 0; j < N; j++) begin
            prod[j] = imm_pkg::fp_mul(m_cbar[j], likelihood[j]);
            total   = total + prod[j];
        end
        for (int j = 0; j < N; j++) begin
            if (total != imm_pkg::FP_ZERO) m_mu[j] = imm_pkg::fp_div(prod[j], total);
            else m_mu[j] = (j == 0) ? imm_pkg::FP_ONE : imm_pkg::FP_ZERO;
        end
        for (int s = 0; s < D; s++) begin
            m_xf[s] = imm_pkg::FP_ZERO;
            for (int j = 0; j < N; j++) begin
                m_xf[s] = m_xf[s] + imm_pkg::fp_mul(m_mu[j], x_filt_model[j][s]);
            end
        end
        m_x = x_filt_model;
    endtask

    // ----------------------------------------
    // Checks and waits
    // ----------------------------------------
    task automatic check_value(input string name, input imm_pkg::fp_t got,
                               input imm_pkg::fp_t exp);
        checks++;
        assert (got === exp) else begin
            $display("ERROR: %s = %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic verify_latency(input string name, input int got, input int exp);
        checks++;
        assert (got == exp) else begin
            $display("ERROR: %s came %0d cycles after its trigger instead of %0d", name, got, exp);
            errors++;
        end
    endtask

    function automatic logic strobe_value(input int which);
        case (which)
            0:       return mix_valid;
            1:       return out_valid;
            default: return done;
        endcase
    endfunction

    // Counts falling edges until the strobe shows, bounded by limit
    task automatic count_to_strobe(input int which, input int start, input int limit,
                                   output int cycles);
        cycles = start;
        while (!strobe_value(which) && cycles < limit) begin
            @(negedge clk);
            cycles++;
        end
        assert (strobe_value(which)) else begin
            $display("Strobe %0d never arrived within %0d cycles", which, limit);
            errors++;
        end
    endtask

    task automatic hold_until_ready();
        int n;
        n = 0;
        while (!ready && n < 50) begin
            @(negedge clk);
            n++;
        end
        assert (ready) else begin
            $display("DUT stayed busy and never returned to ready");
            errors++;
        end
    endtask

    // Filters answer 1 to 8 cycles after mix_valid
    task automatic respond_filters(input bit zero_lik);
        int delay;
        delay = $urandom_range(8, 1);
        repeat (delay) @(negedge clk);
        for (int j = 0; j < N; j++) begin
            likelihood[j] = zero_lik ? imm_pkg::FP_ZERO :
                            imm_pkg::fp_t'($urandom_range(32'h0004_0000, 32'h0000_0100));
            for (int s = 0; s < D; s++) begin
                x_filt_model[j][s] = rand_state();
            end
        end
        filt_valid = 1'b1;
        @(negedge clk);
        filt_valid = 1'b0;
    endtask

    task automatic run_init();
        int cycles;
        int outs;
        hold_until_ready();
        for (int s = 0; s < D; s++) x_init[s] = rand_state();
        meas_req = 1'b1;
        init     = 1'b1;
        outs     = out_pulses;
        @(negedge clk);
        meas_req = 1'b0;
        init     = 1'b0;
        count_to_strobe(2, 1, 10, cycles);
        verify_latency("done", cycles, 2);
        for (int j = 0; j < N; j++) begin
            m_mu[j] = mu_default(j);
            m_x[j]  = x_init;
        end
        for (int j = 0; j < N; j++) begin
            check_value($sformatf("mu[%0d]", j), mu[j], m_mu[j]);
            for (int s = 0; s < D; s++) begin
                check_value($sformatf("x_mixed[%0d][%0d]", j, s), x_mixed[j][s], x_init[s]);
            end
        end
        checks++;
        assert (out_pulses == outs && !out_valid) else begin
            $display("out_valid pulsed during an init request");
            errors++;
        end
    endtask

    // One full normal cycle with its mixing and update checks
    task automatic run_measurement(input bit zero_lik);
        int cycles;
        hold_until_ready();
        meas_req = 1'b1;
        init     = 1'b0;
        @(negedge clk);
        meas_req = 1'b0;
        count_to_strobe(0, 1, 20, cycles);
        verify_latency("mix_valid", cycles, 4);
        model_mix();
        for (int j = 0; j < N; j++) begin
            for (int s = 0; s < D; s++) begin
                check_value($sformatf("x_mixed[%0d][%0d]", j, s), x_mixed[j][s], m_mixed[j][s]);
            end
        end
        respond_filters(zero_lik);
        count_to_strobe(1, 1, 20, cycles);
        verify_latency("out_valid", cycles, 3);
        model_update();
        for (int j = 0; j < N; j++) check_value($sformatf("mu[%0d]", j), mu[j], m_mu[j]);
        for (int s = 0; s < D; s++) check_value($sformatf("x_filt[%0d]", s), x_filt[s], m_xf[s]);
        count_to_strobe(2, 0, 4, cycles);
        verify_latency("done", cycles, 1);
    endtask

    task automatic report_test(input string name);
        tests++;
        if (errors == test_err_base) $display("Test %0d %s: ok", tests, name);
        else $display("Test %0d %s: %0d errors", tests, name, errors - test_err_base);
        test_err_base = errors;
    endtask

    // ----------------------------------------
    // Main sequence
    // ----------------------------------------
    initial begin
        void'($urandom(32'hcfd));
        rst_n         = 1'b0;
        meas_req      = 1'b0;
        init          = 1'b0;
        filt_valid    = 1'b0;
        noise_en      = 1'b0;
        p_stay        = 32'sh0000_E666;
        errors        = 0;
        checks        = 0;
        tests         = 0;
        test_err_base = 0;
        for (int j = 0; j < N; j++) begin
            likelihood[j] = imm_pkg::FP_ZERO;
            for (int s = 0; s < D; s++) x_filt_model[j][s] = imm_pkg::FP_ZERO;
        end
        for (int s = 0; s < D; s++) x_init[s] = imm_pkg::FP_ZERO;
        for (int k = 0; k < 256; k++) noise_bits[k] = $urandom_range(1, 0);

        repeat (4) @(negedge clk);
        rst_n = 1'b1;

        // Reset values, then an init request
        for (int j = 0; j < N; j++) check_value($sformatf("mu[%0d]", j), mu[j], mu_default(j));
        for (int s = 0; s < D; s++) check_value($sformatf("x_filt[%0d]", s), x_filt[s], 0);
        check_value("ready", ready, 1);
        check_value("mix_valid", mix_valid, 0);
        check_value("out_valid", out_valid, 0);
        check_value("done", done, 0);
        run_init();
        report_test("reset and init");

        // Random p_stay, 0.5 up to about 0.99
        p_stay = imm_pkg::fp_t'($urandom_range(32'h0000_FD70, 32'h0000_8000));
        repeat (N_RUN) run_measurement(1'b0);
        report_test("mixing and update");

        // All filters report zero likelihood
        run_measurement(1'b1);
        check_value("mu[0] fallback", mu[0], imm_pkg::FP_ONE);
        for (int j = 1; j < N; j++) check_value($sformatf("mu[%0d] fallback", j), mu[j], 0);
        run_measurement(1'b0);
        report_test("zero likelihood");

        // Init again with the probabilities away from their defaults
        run_init();
        report_test("init after run");

        // Stray requests while busy
        noise_en = 1'b1;
        repeat (N_BUSY) run_measurement(1'b0);
        noise_en = 1'b0;
        @(negedge clk);
        check_value("mix_valid pulses", mix_pulses, accepted_normal);
        report_test("busy requests");

        errors = errors + UUT.u_chk.fail_count;
        $display("Tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
imm_pkg.sv
imm_step_if.sv
imm_ctrl.sv
imm_mixer.sv
imm_prob_update.sv
imm_top.sv
imm_chk.sv
tb_imm_top.sv
